// File: rtl/wan_num_msg_pkg.sv
package wan_num_msg_pkg;

    // Port and field widths
    localparam int KIP_DATA_WIDTH    = 128;
    localparam int MSG_TYPE_WIDTH    = 8;
    localparam int NODE_ID_WIDTH     = 16;
    localparam int SEQ_NUM_WIDTH     = 32;
    localparam int WAN_SEQ_NUM_WIDTH = 32;
    localparam int CTDEST_WIDTH      = 16;
    localparam int IP_ADDR_WIDTH     = 32;
    localparam int IP_PORT_WIDTH     = 16;
    localparam int KIP_TUSER_WIDTH   = 64;
    localparam int RPN_TDEST_WIDTH   = 4;

    // Field offsets in the data beat, message type sits at bit 0
    localparam int SENDER_ID_OFFSET   = 8;
    localparam int SEQ_NUM_OFFSET     = 24;
    localparam int WAN_SEQ_NUM_OFFSET = 56;
    localparam int WAN_CTDEST_OFFSET  = 88;
    localparam int WAN_LOCK_OFFSET    = 104;

    // KIP user word, destination IP address sits at bit 0
    localparam int TUSER_SRC_PORT_OFFSET  = 32;
    localparam int TUSER_DEST_PORT_OFFSET = 48;

    // Message type codes
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_WAN_NUM_SEQ_NUM_CHECK = 8'h10;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_WAN_NUM_SEQ_NUM_REPLY = 8'h11;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_OUT_SEQ_NUM_REQUEST   = 8'h20;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_OUT_SEQ_NUM_REPLY     = 8'h21;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_OUT_SEQ_NUM_CHECK     = 8'h22;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_OUT_SEQ_NUM_RDATA     = 8'h23;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_OUT_SEQ_NUM_WRITE     = 8'h24;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_OUT_SEQ_NUM_BRESP     = 8'h25;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_IN_SEQ_NUM_REQUEST    = 8'h30;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_IN_SEQ_NUM_REPLY      = 8'h31;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_IN_SEQ_NUM_WRITE      = 8'h32;
    localparam logic [MSG_TYPE_WIDTH-1:0] MSG_IN_SEQ_NUM_BRESP      = 8'h33;

    // Kernel IDs on the result channel
    localparam logic [RPN_TDEST_WIDTH-1:0] ID_RPN_WAN_TX = 4'd1;
    localparam logic [RPN_TDEST_WIDTH-1:0] ID_RPN_KIP_RX = 4'd2;
    localparam logic [RPN_TDEST_WIDTH-1:0] ID_RPN_KIP_TX = 4'd3;

endpackage

// File: rtl/wan_num_ctrl_pkg.sv
package wan_num_ctrl_pkg;

    // Cycles spent waiting for an answer before the message is sent again
    localparam int ACK_TIMEOUT       = 1800;
    localparam int SEQ_REPLY_TIMEOUT = 1800;

    // One counter serves both wait states
    localparam int MAX_TIMEOUT = (ACK_TIMEOUT > SEQ_REPLY_TIMEOUT) ?
                                 ACK_TIMEOUT : SEQ_REPLY_TIMEOUT;
    localparam int RETRY_TIMER_WIDTH = $clog2(MAX_TIMEOUT + 1);

    localparam int STATE_WIDTH = 3;

    // Start-up states
    localparam logic [STATE_WIDTH-1:0] ST_INIT        = 3'd0;
    localparam logic [STATE_WIDTH-1:0] ST_SEND_CHECK  = 3'd1;
    localparam logic [STATE_WIDTH-1:0] ST_WAIT_REPLY  = 3'd2;
    // Normal operation
    localparam logic [STATE_WIDTH-1:0] ST_IDLE        = 3'd3;
    localparam logic [STATE_WIDTH-1:0] ST_SEND_REQ    = 3'd4;
    localparam logic [STATE_WIDTH-1:0] ST_WAIT_ACK    = 3'd5;
    localparam logic [STATE_WIDTH-1:0] ST_SEND_RESULT = 3'd6;

endpackage

// File: rtl/wan_num_client_fsm.sv
module wan_num_client_fsm (
    input  logic i_clk,
    input  logic i_ap_rst_n,
    input  logic i_rpn_tvalid,
    input  logic i_kip_tready,
    input  logic i_res_tready,
    input  logic i_reply_match,
    input  logic i_ack_match,
    input  logic i_needs_result,
    output logic o_rpn_tready,
    output logic o_kip_tvalid,
    output logic o_nb_tready,
    output logic o_res_tvalid,
    output logic o_init_load,
    output logic o_req_accept,
    output logic o_seq_load,
    output logic o_clear,
    output logic o_capture
);

    import wan_num_ctrl_pkg::*;

    logic [STATE_WIDTH-1:0]       r_state;
    logic [STATE_WIDTH-1:0]       w_next_state;
    logic [RETRY_TIMER_WIDTH-1:0] r_timer;
    logic                         w_reply_timeout;
    logic                         w_ack_timeout;
    logic                         w_stay_waiting;

    assign w_reply_timeout = (r_timer == RETRY_TIMER_WIDTH'(SEQ_REPLY_TIMEOUT));
    assign w_ack_timeout   = (r_timer == RETRY_TIMER_WIDTH'(ACK_TIMEOUT));

    // Channel levels follow the state only
    assign o_rpn_tready = (r_state == ST_IDLE);
    // Late answers are drained in idle and dropped
    assign o_nb_tready  = (r_state == ST_WAIT_REPLY) || (r_state == ST_IDLE)
                       || (r_state == ST_WAIT_ACK);
    assign o_kip_tvalid = (r_state == ST_SEND_CHECK) || (r_state == ST_SEND_REQ);
    assign o_res_tvalid = (r_state == ST_SEND_RESULT);

    // Strobes to the tracker and the checker
    assign o_init_load  = (r_state == ST_INIT);
    assign o_req_accept = (r_state == ST_IDLE) && i_rpn_tvalid;
    assign o_clear      = (r_state == ST_IDLE) && !i_rpn_tvalid;
    assign o_seq_load   = (r_state == ST_WAIT_REPLY) && i_reply_match;
    assign o_capture    = (r_state == ST_WAIT_ACK) && i_ack_match;

    always_comb begin
        w_next_state = r_state;
        case (r_state)
            ST_INIT: begin
                w_next_state = ST_SEND_CHECK;
            end
            ST_SEND_CHECK: begin
                if (i_kip_tready)
                    w_next_state = ST_WAIT_REPLY;
            end
            ST_WAIT_REPLY: begin
                // A matching reply wins over a timeout in the same cycle
                if (i_reply_match)
                    w_next_state = ST_IDLE;
                else if (w_reply_timeout)
                    w_next_state = ST_SEND_CHECK;
            end
            ST_IDLE: begin
                if (i_rpn_tvalid)
                    w_next_state = ST_SEND_REQ;
            end
            ST_SEND_REQ: begin
                if (i_kip_tready)
                    w_next_state = ST_WAIT_ACK;
            end
            ST_WAIT_ACK: begin
                // Writes finish on their BRESP without a result
                if (i_ack_match)
                    w_next_state = i_needs_result ? ST_SEND_RESULT : ST_IDLE;
                else if (w_ack_timeout)
                    w_next_state = ST_SEND_REQ;
            end
            ST_SEND_RESULT: begin
                if (i_res_tready)
                    w_next_state = ST_IDLE;
            end
            default: begin
                w_next_state = ST_INIT;
            end
        endcase
    end

    // Counter runs only while a wait state is held
    assign w_stay_waiting = (w_next_state == r_state)
                         && ((r_state == ST_WAIT_REPLY) || (r_state == ST_WAIT_ACK));

    always_ff @(posedge i_clk or negedge i_ap_rst_n) begin
        if (!i_ap_rst_n) begin
            r_state <= ST_INIT;
            r_timer <= '0;
        end else begin
            r_state <= w_next_state;
            r_timer <= w_stay_waiting ? r_timer + 1'b1 : '0;
        end
    end

endmodule

// File: rtl/wan_num_request_tracker.sv
module wan_num_request_tracker (
    input  logic                                          i_clk,
    input  logic                                          i_ap_rst_n,
    input  logic                                          i_init_load,
    input  logic                                          i_req_accept,
    input  logic                                          i_seq_load,
    input  logic                                          i_clear,
    input  logic [wan_num_msg_pkg::MSG_TYPE_WIDTH-1:0]    i_rpn_tdata,
    input  logic [wan_num_msg_pkg::CTDEST_WIDTH-1:0]      i_rpn_tdest,
    input  logic [wan_num_msg_pkg::SEQ_NUM_WIDTH-1:0]     i_reply_seq_num,
    input  logic [wan_num_msg_pkg::NODE_ID_WIDTH-1:0]     i_node_id,
    input  logic [wan_num_msg_pkg::IP_ADDR_WIDTH-1:0]     i_wan_node_ip_addr,
    input  logic [wan_num_msg_pkg::IP_PORT_WIDTH-1:0]     i_kip_port,
    output logic [wan_num_msg_pkg::KIP_DATA_WIDTH-1:0]    o_kip_tdata,
    output logic [wan_num_msg_pkg::KIP_TUSER_WIDTH-1:0]   o_kip_tuser,
    output logic [wan_num_msg_pkg::MSG_TYPE_WIDTH-1:0]    o_expected_reply,
    output logic [wan_num_msg_pkg::SEQ_NUM_WIDTH-1:0]     o_seq_num,
    output logic                                          o_needs_result,
    output logic [wan_num_msg_pkg::RPN_TDEST_WIDTH-1:0]   o_res_tdest
);

    import wan_num_msg_pkg::*;

    logic [MSG_TYPE_WIDTH-1:0] r_msg_type;
    logic [MSG_TYPE_WIDTH-1:0] r_expected_reply;
    logic [MSG_TYPE_WIDTH-1:0] w_req_reply;
    logic [CTDEST_WIDTH-1:0]   r_ctdest;
    logic [SEQ_NUM_WIDTH-1:0]  r_seq_num;

    // Reply that answers each request type, unknown types get 0
    always_comb begin
        case (i_rpn_tdata)
            MSG_OUT_SEQ_NUM_REQUEST: w_req_reply = MSG_OUT_SEQ_NUM_REPLY;
            MSG_OUT_SEQ_NUM_CHECK:   w_req_reply = MSG_OUT_SEQ_NUM_RDATA;
            MSG_OUT_SEQ_NUM_WRITE:   w_req_reply = MSG_OUT_SEQ_NUM_BRESP;
            MSG_IN_SEQ_NUM_REQUEST:  w_req_reply = MSG_IN_SEQ_NUM_REPLY;
            MSG_IN_SEQ_NUM_WRITE:    w_req_reply = MSG_IN_SEQ_NUM_BRESP;
            default:                 w_req_reply = '0;
        endcase
    end

    // Fields stay put between strobes so a retry resends the same beat
    always_ff @(posedge i_clk or negedge i_ap_rst_n) begin
        if (!i_ap_rst_n) begin
            r_msg_type       <= '0;
            r_expected_reply <= '0;
            r_ctdest         <= '0;
            r_seq_num        <= '0;
        end else if (i_init_load) begin
            r_msg_type       <= MSG_WAN_NUM_SEQ_NUM_CHECK;
            r_expected_reply <= MSG_WAN_NUM_SEQ_NUM_REPLY;
            r_ctdest         <= '0;
        end else if (i_req_accept) begin
            r_msg_type       <= i_rpn_tdata;
            r_expected_reply <= w_req_reply;
            r_ctdest         <= i_rpn_tdest;
            r_seq_num        <= r_seq_num + 1'b1;
        end else if (i_seq_load) begin
            r_seq_num        <= i_reply_seq_num;
        end else if (i_clear) begin
            r_msg_type       <= '0;
            r_expected_reply <= '0;
            r_ctdest         <= '0;
        end
    end

    // Outgoing beat, the WAN number field and upper bits stay zero
    always_comb begin
        o_kip_tdata = '0;
        o_kip_tdata[0+:MSG_TYPE_WIDTH]                 = r_msg_type;
        o_kip_tdata[SENDER_ID_OFFSET+:NODE_ID_WIDTH]   = i_node_id;
        o_kip_tdata[SEQ_NUM_OFFSET+:SEQ_NUM_WIDTH]     = r_seq_num;
        o_kip_tdata[WAN_CTDEST_OFFSET+:CTDEST_WIDTH]   = r_ctdest;
    end

    // Same port number on both ends
    always_comb begin
        o_kip_tuser = '0;
        o_kip_tuser[0+:IP_ADDR_WIDTH]                      = i_wan_node_ip_addr;
        o_kip_tuser[TUSER_SRC_PORT_OFFSET+:IP_PORT_WIDTH]  = i_kip_port;
        o_kip_tuser[TUSER_DEST_PORT_OFFSET+:IP_PORT_WIDTH] = i_kip_port;
    end

    assign o_expected_reply = r_expected_reply;
    assign o_seq_num        = r_seq_num;
    assign o_needs_result   = (r_expected_reply != MSG_OUT_SEQ_NUM_BRESP)
                           && (r_expected_reply != MSG_IN_SEQ_NUM_BRESP);

    // Result goes back to the kernel that asked
    always_comb begin
        case (r_msg_type)
            MSG_OUT_SEQ_NUM_REQUEST: o_res_tdest = ID_RPN_WAN_TX;
            MSG_OUT_SEQ_NUM_CHECK:   o_res_tdest = ID_RPN_KIP_RX;
            MSG_IN_SEQ_NUM_REQUEST:  o_res_tdest = ID_RPN_KIP_TX;
            default:                 o_res_tdest = '0;
        endcase
    end

endmodule

// File: rtl/wan_num_reply_checker.sv
module wan_num_reply_checker (
    input  logic                                            i_clk,
    input  logic                                            i_ap_rst_n,
    input  logic                                            i_nb_tvalid,
    input  logic [wan_num_msg_pkg::KIP_DATA_WIDTH-1:0]      i_nb_tdata,
    input  logic [wan_num_msg_pkg::NODE_ID_WIDTH-1:0]       i_wan_node_id,
    input  logic [wan_num_msg_pkg::MSG_TYPE_WIDTH-1:0]      i_expected_reply,
    input  logic [wan_num_msg_pkg::SEQ_NUM_WIDTH-1:0]       i_seq_num,
    input  logic                                            i_capture,
    input  logic                                            i_clear,
    output logic                                            o_reply_match,
    output logic                                            o_ack_match,
    output logic [wan_num_msg_pkg::SEQ_NUM_WIDTH-1:0]       o_reply_seq_num,
    output logic [wan_num_msg_pkg::WAN_SEQ_NUM_WIDTH-1:0]   o_res_tdata,
    output logic                                            o_res_tuser
);

    import wan_num_msg_pkg::*;

    logic [MSG_TYPE_WIDTH-1:0]    w_msg_type;
    logic [NODE_ID_WIDTH-1:0]     w_sender_id;
    logic [WAN_SEQ_NUM_WIDTH-1:0] w_wan_seq_num;
    logic                         w_wan_lock;
    logic [WAN_SEQ_NUM_WIDTH-1:0] r_wan_seq_num;
    logic                         r_wan_lock;

    // Field decode of the bridge beat
    assign w_msg_type      = i_nb_tdata[0+:MSG_TYPE_WIDTH];
    assign w_sender_id     = i_nb_tdata[SENDER_ID_OFFSET+:NODE_ID_WIDTH];
    assign o_reply_seq_num = i_nb_tdata[SEQ_NUM_OFFSET+:SEQ_NUM_WIDTH];
    assign w_wan_seq_num   = i_nb_tdata[WAN_SEQ_NUM_OFFSET+:WAN_SEQ_NUM_WIDTH];
    assign w_wan_lock      = i_nb_tdata[WAN_LOCK_OFFSET];

    assign o_reply_match = i_nb_tvalid && (w_msg_type == i_expected_reply);
    // Stale acks from an earlier transaction fail the sequence compare
    assign o_ack_match   = o_reply_match && (w_sender_id == i_wan_node_id)
                        && (o_reply_seq_num == i_seq_num);

    always_ff @(posedge i_clk or negedge i_ap_rst_n) begin
        if (!i_ap_rst_n) begin
            r_wan_seq_num <= '0;
            r_wan_lock    <= 1'b0;
        end else if (i_capture) begin
            r_wan_seq_num <= w_wan_seq_num;
            r_wan_lock    <= w_wan_lock;
        end else if (i_clear) begin
            r_wan_seq_num <= '0;
            r_wan_lock    <= 1'b0;
        end
    end

    assign o_res_tdata = r_wan_seq_num;
    assign o_res_tuser = r_wan_lock;

endmodule

// File: rtl/wan_num_client.sv
module wan_num_client (
    input  logic                                            i_clk,
    input  logic                                            i_ap_rst_n,
    input  logic [wan_num_msg_pkg::NODE_ID_WIDTH-1:0]       i_node_id,
    input  logic [wan_num_msg_pkg::NODE_ID_WIDTH-1:0]       i_wan_node_id,
    input  logic [wan_num_msg_pkg::IP_ADDR_WIDTH-1:0]       i_wan_node_ip_addr,
    input  logic [wan_num_msg_pkg::IP_PORT_WIDTH-1:0]       i_kip_port,
    // Kernel requests
    input  logic                                            i_rpn_tvalid,
    output logic                                            o_rpn_tready,
    input  logic [wan_num_msg_pkg::MSG_TYPE_WIDTH-1:0]      i_rpn_tdata,
    input  logic [wan_num_msg_pkg::CTDEST_WIDTH-1:0]        i_rpn_tdest,
    // KIP transmit
    output logic                                            o_kip_tvalid,
    input  logic                                            i_kip_tready,
    output logic [wan_num_msg_pkg::KIP_DATA_WIDTH-1:0]      o_kip_tdata,
    output logic [wan_num_msg_pkg::KIP_TUSER_WIDTH-1:0]     o_kip_tuser,
    // Bridge receive
    input  logic                                            i_nb_tvalid,
    output logic                                            o_nb_tready,
    input  logic [wan_num_msg_pkg::KIP_DATA_WIDTH-1:0]      i_nb_tdata,
    // Results to kernels
    output logic                                            o_res_tvalid,
    input  logic                                            i_res_tready,
    output logic [wan_num_msg_pkg::WAN_SEQ_NUM_WIDTH-1:0]   o_res_tdata,
    output logic [wan_num_msg_pkg::RPN_TDEST_WIDTH-1:0]     o_res_tdest,
    output logic                                            o_res_tuser
);

    import wan_num_msg_pkg::*;

    logic                      w_init_load;
    logic                      w_req_accept;
    logic                      w_seq_load;
    logic                      w_clear;
    logic                      w_capture;
    logic                      w_reply_match;
    logic                      w_ack_match;
    logic                      w_needs_result;
    logic [MSG_TYPE_WIDTH-1:0] w_expected_reply;
    logic [SEQ_NUM_WIDTH-1:0]  w_seq_num;
    logic [SEQ_NUM_WIDTH-1:0]  w_reply_seq_num;

    wan_num_client_fsm u_fsm (
        .i_clk          (i_clk),
        .i_ap_rst_n     (i_ap_rst_n),
        .i_rpn_tvalid   (i_rpn_tvalid),
        .i_kip_tready   (i_kip_tready),
        .i_res_tready   (i_res_tready),
        .i_reply_match  (w_reply_match),
        .i_ack_match    (w_ack_match),
        .i_needs_result (w_needs_result),
        .o_rpn_tready   (o_rpn_tready),
        .o_kip_tvalid   (o_kip_tvalid),
        .o_nb_tready    (o_nb_tready),
        .o_res_tvalid   (o_res_tvalid),
        .o_init_load    (w_init_load),
        .o_req_accept   (w_req_accept),
        .o_seq_load     (w_seq_load),
        .o_clear        (w_clear),
        .o_capture      (w_capture)
    );

    wan_num_request_tracker u_tracker (
        .i_clk              (i_clk),
        .i_ap_rst_n         (i_ap_rst_n),
        .i_init_load        (w_init_load),
        .i_req_accept       (w_req_accept),
        .i_seq_load         (w_seq_load),
        .i_clear            (w_clear),
        .i_rpn_tdata        (i_rpn_tdata),
        .i_rpn_tdest        (i_rpn_tdest),
        .i_reply_seq_num    (w_reply_seq_num),
        .i_node_id          (i_node_id),
        .i_wan_node_ip_addr (i_wan_node_ip_addr),
        .i_kip_port         (i_kip_port),
        .o_kip_tdata        (o_kip_tdata),
        .o_kip_tuser        (o_kip_tuser),
        .o_expected_reply   (w_expected_reply),
        .o_seq_num          (w_seq_num),
        .o_needs_result     (w_needs_result),
        .o_res_tdest        (o_res_tdest)
    );

    wan_num_reply_checker u_checker (
        .i_clk            (i_clk),
        .i_ap_rst_n       (i_ap_rst_n),
        .i_nb_tvalid      (i_nb_tvalid),
        .i_nb_tdata       (i_nb_tdata),
        .i_wan_node_id    (i_wan_node_id),
        .i_expected_reply (w_expected_reply),
        .i_seq_num        (w_seq_num),
        .i_capture        (w_capture),
        .i_clear          (w_clear),
        .o_reply_match    (w_reply_match),
        .o_ack_match      (w_ack_match),
        .o_reply_seq_num  (w_reply_seq_num),
        .o_res_tdata      (o_res_tdata),
        .o_res_tuser      (o_res_tuser)
    );

endmodule

// File: testbench/tb_wan_num_client_tests.svh
// Request from the kernel and check the KIP message it produces
task automatic request_message(input logic [MSG_TYPE_WIDTH-1:0] msg_type, input string name);
    int                      cycles;
    logic [CTDEST_WIDTH-1:0] cluster;
    cluster = CTDEST_WIDTH'(lfsr_bits(CTDEST_WIDTH));
    issue_request(msg_type, cluster);
    exp_seq       = exp_seq + 1;
    last_kip_data = make_beat(msg_type, NODE_ID, exp_seq, '0, cluster, 1'b0);
    wait_kip(WAIT_LIMIT, cycles);
    check_value(name, "kip data", last_kip_data, o_kip_tdata);
    check_value(name, "kip user", EXP_USER, o_kip_tuser);
    @(negedge i_clk);
endtask

// Correct ack followed by a result that carries its WAN number and lock
task automatic finish_with_result(input logic [MSG_TYPE_WIDTH-1:0] reply,
                                  input logic [RPN_TDEST_WIDTH-1:0] dest,
                                  input logic hold, input string name);
    logic [WAN_SEQ_NUM_WIDTH-1:0] wan;
    logic                         lock;
    wan  = WAN_SEQ_NUM_WIDTH'(lfsr_bits(WAN_SEQ_NUM_WIDTH));
    lock = 1'(lfsr_bits(1));
    if (hold)
        i_res_tready = 1'b0;
    send_beat(make_beat(reply, WAN_NODE_ID, exp_seq, wan, '0, lock));
    wait_result();
    check_value(name, "result data", wan, o_res_tdata);
    check_value(name, "result dest", dest, o_res_tdest);
    check_value(name, "result lock", lock, o_res_tuser);
    if (hold) begin
        repeat (3) @(negedge i_clk);
        check_value(name, "held valid", 1, o_res_tvalid);
        check_value(name, "held data", wan, o_res_tdata);
        check_value(name, "held dest", dest, o_res_tdest);
        check_value(name, "held lock", lock, o_res_tuser);
        i_res_tready = 1'b1;
    end
    @(negedge i_clk);
    check_value(name, "idle after result", 1, o_rpn_tready);
endtask

task automatic initial_check_message();
    int                        cycles;
    logic [KIP_DATA_WIDTH-1:0] exp_data;
    exp_data = make_beat(MSG_WAN_NUM_SEQ_NUM_CHECK, NODE_ID, '0, '0, '0, 1'b0);
    wait_kip(WAIT_LIMIT, cycles);
    check_value("init_check", "kip data", exp_data, o_kip_tdata);
    check_value("init_check", "kip user", EXP_USER, o_kip_tuser);
    // KIP back-pressure must hold the message
    repeat (3) @(negedge i_clk);
    check_value("init_check", "held valid", 1, o_kip_tvalid);
    check_value("init_check", "held data", exp_data, o_kip_tdata);
    i_kip_tready = 1'b1;
    @(negedge i_clk);
endtask

task automatic initial_reply_and_increment();
    logic [SEQ_NUM_WIDTH-1:0] seq;
    seq = SEQ_NUM_WIDTH'(lfsr_bits(SEQ_NUM_WIDTH));
    // Wrong type is drained but not taken as the reply
    send_beat(make_beat(MSG_OUT_SEQ_NUM_REPLY, WAN_NODE_ID, ~seq, '0, '0, 1'b0));
    check_value("init_reply", "idle after wrong type", 0, o_rpn_tready);
    send_beat(make_beat(MSG_WAN_NUM_SEQ_NUM_REPLY, WAN_NODE_ID, seq, '0, '0, 1'b0));
    check_value("init_reply", "idle after reply", 1, o_rpn_tready);
    exp_seq = seq;
    request_message(MSG_OUT_SEQ_NUM_REQUEST, "first_request");
    finish_with_result(MSG_OUT_SEQ_NUM_REPLY, ID_RPN_WAN_TX, 1'b0, "first_request");
endtask

task automatic result_return();
    request_message(MSG_IN_SEQ_NUM_REQUEST, "in_request");
    finish_with_result(MSG_IN_SEQ_NUM_REPLY, ID_RPN_KIP_TX, 1'b1, "in_request");
    request_message(MSG_OUT_SEQ_NUM_CHECK, "out_check");
    finish_with_result(MSG_OUT_SEQ_NUM_RDATA, ID_RPN_KIP_RX, 1'b0, "out_check");
    request_message(MSG_OUT_SEQ_NUM_REQUEST, "out_request");
    finish_with_result(MSG_OUT_SEQ_NUM_REPLY, ID_RPN_WAN_TX, 1'b1, "out_request");
endtask

task automatic ignored_acks();
    request_message(MSG_OUT_SEQ_NUM_REQUEST, "bad_ack");
    send_beat(make_beat(MSG_OUT_SEQ_NUM_REPLY, WAN_NODE_ID, exp_seq ^ 32'h1, 32'h5a5a, '0, 1'b1));
    check_value("bad_ack", "result on wrong seq", 0, o_res_tvalid);
    check_value("bad_ack", "waiting after wrong seq", 1, o_nb_tready);
    send_beat(make_beat(MSG_OUT_SEQ_NUM_REPLY, WAN_NODE_ID ^ 16'h0100, exp_seq, 32'h5a5a, '0,
                        1'b1));
    check_value("bad_ack", "result on wrong sender", 0, o_res_tvalid);
    check_value("bad_ack", "waiting after wrong sender", 1, o_nb_tready);
    finish_with_result(MSG_OUT_SEQ_NUM_REPLY, ID_RPN_WAN_TX, 1'b0, "bad_ack");
    // Writes end on BRESP with no result
    request_message(MSG_OUT_SEQ_NUM_WRITE, "out_write");
    send_beat(make_beat(MSG_OUT_SEQ_NUM_BRESP, WAN_NODE_ID, exp_seq, '0, '0, 1'b0));
    check_value("out_write", "no result", 0, o_res_tvalid);
    check_value("out_write", "idle after bresp", 1, o_rpn_tready);
    request_message(MSG_IN_SEQ_NUM_WRITE, "in_write");
    send_beat(make_beat(MSG_IN_SEQ_NUM_BRESP, WAN_NODE_ID, exp_seq, '0, '0, 1'b0));
    check_value("in_write", "no result", 0, o_res_tvalid);
    check_value("in_write", "idle after bresp", 1, o_rpn_tready);
    request_message(MSG_OUT_SEQ_NUM_CHECK, "after_write");
    finish_with_result(MSG_OUT_SEQ_NUM_RDATA, ID_RPN_KIP_RX, 1'b0, "after_write");
endtask

task automatic retransmit_on_timeout();
    int cycles;
    request_message(MSG_IN_SEQ_NUM_REQUEST, "retransmit");
    wait_kip(ACK_TIMEOUT + 20, cycles);
    check_value("retransmit", "kip data", last_kip_data, o_kip_tdata);
    check_value("retransmit", "kip user", EXP_USER, o_kip_tuser);
    check_value("retransmit", "not before timeout", 1, cycles >= ACK_TIMEOUT);
    @(negedge i_clk);
    finish_with_result(MSG_IN_SEQ_NUM_REPLY, ID_RPN_KIP_TX, 1'b0, "retransmit");
endtask

// File: testbench/tb_wan_num_client.sv
module tb_wan_num_client;

    import wan_num_msg_pkg::*;
    import wan_num_ctrl_pkg::*;

    localparam int WAIT_LIMIT = 5000;
    localparam logic [NODE_ID_WIDTH-1:0] NODE_ID     = 16'h0a05;
    localparam logic [NODE_ID_WIDTH-1:0] WAN_NODE_ID = 16'h00c3;
    localparam logic [IP_ADDR_WIDTH-1:0] WAN_NODE_IP = 32'hc0a8_0142;
    localparam logic [IP_PORT_WIDTH-1:0] KIP_PORT    = 16'd5001;
    // Port number in both port fields and the IP address in the low word
    localparam logic [KIP_TUSER_WIDTH-1:0] EXP_USER = {KIP_PORT, KIP_PORT, WAN_NODE_IP};

    logic                         i_clk;
    logic                         i_ap_rst_n;
    logic [NODE_ID_WIDTH-1:0]     i_node_id;
    logic [NODE_ID_WIDTH-1:0]     i_wan_node_id;
    logic [IP_ADDR_WIDTH-1:0]     i_wan_node_ip_addr;
    logic [IP_PORT_WIDTH-1:0]     i_kip_port;
    logic                         i_rpn_tvalid;
    logic                         o_rpn_tready;
    logic [MSG_TYPE_WIDTH-1:0]    i_rpn_tdata;
    logic [CTDEST_WIDTH-1:0]      i_rpn_tdest;
    logic                         o_kip_tvalid;
    logic                         i_kip_tready;
    logic [KIP_DATA_WIDTH-1:0]    o_kip_tdata;
    logic [KIP_TUSER_WIDTH-1:0]   o_kip_tuser;
    logic                         i_nb_tvalid;
    logic                         o_nb_tready;
    logic [KIP_DATA_WIDTH-1:0]    i_nb_tdata;
    logic                         o_res_tvalid;
    logic                         i_res_tready;
    logic [WAN_SEQ_NUM_WIDTH-1:0] o_res_tdata;
    logic [RPN_TDEST_WIDTH-1:0]   o_res_tdest;
    logic                         o_res_tuser;

    int                        value_errors;
    int                        timeouts;
    logic [15:0]               lfsr_state;
    // Model of the client sequence number and of the last KIP beat expected
    logic [SEQ_NUM_WIDTH-1:0]  exp_seq;
    logic [KIP_DATA_WIDTH-1:0] last_kip_data;

    wan_num_client dut0 (.*);

    always #2 i_clk = ~i_clk;

    // Taps 16, 14, 13, 11
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [KIP_DATA_WIDTH-1:0] make_beat(
        input logic [MSG_TYPE_WIDTH-1:0]    msg_type,
        input logic [NODE_ID_WIDTH-1:0]     sender,
        input logic [SEQ_NUM_WIDTH-1:0]     seq,
        input logic [WAN_SEQ_NUM_WIDTH-1:0] wan,
        input logic [CTDEST_WIDTH-1:0]      ctdest,
        input logic                         lock
    );
        logic [KIP_DATA_WIDTH-1:0] d;
        d = '0;
        d[0+:MSG_TYPE_WIDTH]                   = msg_type;
        d[SENDER_ID_OFFSET+:NODE_ID_WIDTH]     = sender;
        d[SEQ_NUM_OFFSET+:SEQ_NUM_WIDTH]       = seq;
        d[WAN_SEQ_NUM_OFFSET+:WAN_SEQ_NUM_WIDTH] = wan;
        d[WAN_CTDEST_OFFSET+:CTDEST_WIDTH]     = ctdest;
        d[WAN_LOCK_OFFSET]                     = lock;
        return d;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [127:0] expected, input logic [127:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("error %s %s: expected %0h, actual %0h", test, what, expected, actual);
        end
    endtask

    // Bridge model that holds one beat until the DUT takes it
    task automatic send_beat(input logic [KIP_DATA_WIDTH-1:0] data);
        int n;
        n = 0;
        i_nb_tvalid = 1'b1;
        i_nb_tdata  = data;
        while (!o_nb_tready && n < WAIT_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_nb_tready) begin
            timeouts++;
            $display("timeout: the bridge beat was never taken");
        end
        @(negedge i_clk);
        i_nb_tvalid = 1'b0;
    endtask

    // Kernel model driving one request word
    task automatic issue_request(input logic [MSG_TYPE_WIDTH-1:0] msg_type,
                                 input logic [CTDEST_WIDTH-1:0] cluster);
        int n;
        n = 0;
        i_rpn_tvalid = 1'b1;
        i_rpn_tdata  = msg_type;
        i_rpn_tdest  = cluster;
        while (!o_rpn_tready && n < WAIT_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_rpn_tready) begin
            timeouts++;
            $display("timeout: the kernel request was never accepted");
        end
        @(negedge i_clk);
        i_rpn_tvalid = 1'b0;
    endtask

    task automatic wait_kip(input int limit, output int cycles);
        cycles = 0;
        while (!o_kip_tvalid && cycles < limit) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_kip_tvalid) begin
            timeouts++;
            $display("timeout: no KIP message within %0d cycles", limit);
        end
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (!o_res_tvalid && n < WAIT_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_res_tvalid) begin
            timeouts++;
            $display("timeout: no result was returned to the kernel");
        end
    endtask

`include "tb_wan_num_client_tests.svh"

    initial begin
        i_clk              = 1'b0;
        i_ap_rst_n         = 1'b0;
        i_node_id          = NODE_ID;
        i_wan_node_id      = WAN_NODE_ID;
        i_wan_node_ip_addr = WAN_NODE_IP;
        i_kip_port         = KIP_PORT;
        i_rpn_tvalid       = 1'b0;
        i_rpn_tdata        = '0;
        i_rpn_tdest        = '0;
        i_kip_tready       = 1'b0;
        i_nb_tvalid        = 1'b0;
        i_nb_tdata         = '0;
        i_res_tready       = 1'b1;
        value_errors       = 0;
        timeouts           = 0;
        lfsr_state         = 16'd2553;
        exp_seq            = '0;
        last_kip_data      = '0;
        repeat (3) @(negedge i_clk);
        i_ap_rst_n = 1'b1;
        initial_check_message();
        initial_reply_and_increment();
        result_return();
        ignored_acks();
        retransmit_on_timeout();
        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+testbench
rtl/wan_num_msg_pkg.sv
rtl/wan_num_ctrl_pkg.sv
rtl/wan_num_client_fsm.sv
rtl/wan_num_request_tracker.sv
rtl/wan_num_reply_checker.sv
rtl/wan_num_client.sv
testbench/tb_wan_num_client.sv

// File: Bender.yml
package:
  name: wan_num_client

sources:
  - rtl/wan_num_msg_pkg.sv
  - rtl/wan_num_ctrl_pkg.sv
  - rtl/wan_num_client_fsm.sv
  - rtl/wan_num_request_tracker.sv
  - rtl/wan_num_reply_checker.sv
  - rtl/wan_num_client.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_wan_num_client.sv
